/* src/icache_pkg.sv */
package icache_pkg;

  // 2 ways of 4 KiB each with 16-byte lines
  localparam int WAY_CNT    = 2;
  localparam int SET_CNT    = 256;
  localparam int LINE_WORDS = 4;

  typedef logic [31:0]        addr_t;
  typedef logic [31:0]        word_t;
  typedef logic [19:0]        tag_t;      // addr[31:12]
  typedef logic [7:0]         set_idx_t;  // addr[11:4]
  typedef logic [8:0]         pair_idx_t; // addr[11:3]
  typedef logic [WAY_CNT-1:0] way_vec_t;

  typedef enum logic [3:0] {
    IDLE,
    WAIT_BUS,
    LINE_ADDR,
    LINE_DATA,
    REREAD,
    UNC_ADDR0,
    UNC_DATA0,
    UNC_ADDR1,
    UNC_DATA1
  } refill_state_t;

  function automatic tag_t tag_of(input addr_t a);
    return a[31:12];
  endfunction

  function automatic set_idx_t set_of(input addr_t a);
    return a[11:4];
  endfunction

  function automatic pair_idx_t pair_of(input addr_t a);
    return a[11:3];
  endfunction

  // base of the aligned instruction pair
  function automatic addr_t pair_base(input addr_t a);
    return {a[31:3], 3'b000};
  endfunction

endpackage

/* src/icache_tag_ram.sv */
`timescale 1ns/1ps

module icache_tag_ram (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  icache_pkg::set_idx_t                       raddr_i,
  output icache_pkg::tag_t [icache_pkg::WAY_CNT-1:0] rdata_tag_o,
  output icache_pkg::way_vec_t                       rdata_valid_o,
  input  icache_pkg::set_idx_t                       waddr_i,
  input  icache_pkg::way_vec_t                       we_i,
  input  icache_pkg::tag_t                           wtag_i,
  input  logic                                       wvalid_i,
  output logic                                       clear_busy_o
);

  icache_pkg::tag_t     tag_mem [icache_pkg::WAY_CNT][icache_pkg::SET_CNT];
  logic                 vld_mem [icache_pkg::WAY_CNT][icache_pkg::SET_CNT];
  icache_pkg::set_idx_t clear_cnt_q;
  logic                 clear_busy_q;
  icache_pkg::set_idx_t wr_addr;
  icache_pkg::way_vec_t wr_en;
  logic                 wr_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clear_cnt_q  <= '0;
      clear_busy_q <= 1'b1;
    end else if (clear_busy_q) begin
      clear_cnt_q <= clear_cnt_q + 1'b1;
      if (clear_cnt_q == icache_pkg::set_idx_t'(icache_pkg::SET_CNT - 1)) begin
        clear_busy_q <= 1'b0;
      end
    end
  end

  // sweep owns the write port until the last set
  assign wr_addr  = clear_busy_q ? clear_cnt_q : waddr_i;
  assign wr_en    = clear_busy_q ? '1 : we_i;
  assign wr_valid = wvalid_i && !clear_busy_q;

  always_ff @(posedge clk) begin
    for (int w = 0; w < icache_pkg::WAY_CNT; w++) begin
      if (wr_en[w]) begin
        tag_mem[w][wr_addr] <= wtag_i;
        vld_mem[w][wr_addr] <= wr_valid;
      end
      rdata_tag_o[w]   <= tag_mem[w][raddr_i]; // old data on collision
      rdata_valid_o[w] <= vld_mem[w][raddr_i];
    end
  end

  assign clear_busy_o = clear_busy_q;

endmodule

/* src/icache_data_ram.sv */
`timescale 1ns/1ps

module icache_data_ram (
  input  logic                                            clk,
  input  icache_pkg::pair_idx_t                           raddr_i,
  output icache_pkg::word_t [icache_pkg::WAY_CNT-1:0][1:0] rdata_o,
  input  icache_pkg::pair_idx_t                           waddr_i,
  input  logic [1:0]                                      wlane_i,
  input  icache_pkg::way_vec_t                            we_i,
  input  icache_pkg::word_t                               wdata_i
);

  // one row per instruction pair, two rows per line
  icache_pkg::word_t [1:0] mem
    [icache_pkg::WAY_CNT][icache_pkg::SET_CNT * icache_pkg::LINE_WORDS / 2];

  always_ff @(posedge clk) begin
    for (int w = 0; w < icache_pkg::WAY_CNT; w++) begin
      for (int l = 0; l < 2; l++) begin
        if (we_i[w] && wlane_i[l]) begin
          mem[w][waddr_i][l] <= wdata_i;
        end
      end
      rdata_o[w] <= mem[w][raddr_i];
    end
  end

endmodule

/* src/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [1:0]              f2_valid_i,
  input  logic                    f2_excp_i,
  input  logic                    f2_uncached_i,
  input  icache_pkg::addr_t       f2_ppc_i,
  input  logic                    f2_stall_i,
  input  logic                    miss_i,
  input  icache_pkg::way_vec_t    victim_i,
  output logic                    bus_req_valid_o,
  output icache_pkg::addr_t       bus_req_addr_o,
  output logic                    bus_req_burst_o,
  input  logic                    bus_busy_i,
  input  logic                    bus_ready_i,
  input  logic                    bus_data_ok_i,
  input  logic                    bus_data_last_i,
  input  icache_pkg::word_t       bus_rdata_i,
  output icache_pkg::way_vec_t    tag_we_o,
  output icache_pkg::set_idx_t    tag_set_o,
  output icache_pkg::tag_t        tag_o,
  output icache_pkg::way_vec_t    data_we_o,
  output icache_pkg::pair_idx_t   data_row_o,
  output logic [1:0]              data_lane_o,
  output icache_pkg::word_t       data_word_o,
  output icache_pkg::word_t [1:0] unc_words_o,
  output logic                    busy_o,
  output logic                    reread_o
);

  icache_pkg::refill_state_t                state_q, state_d;
  logic [$clog2(icache_pkg::LINE_WORDS)-1:0] beat_q;
  icache_pkg::way_vec_t                     way_q;
  icache_pkg::word_t [1:0]                  unc_q;
  logic                                     served_q;
  logic                                     need_line;
  logic                                     need_unc;
  logic                                     unc_done;

  assign need_line = |f2_valid_i && !f2_excp_i && !f2_uncached_i && miss_i;
  assign need_unc  = |f2_valid_i && !f2_excp_i && f2_uncached_i && !served_q;

  // group finished once its last valid slot has its word
  assign unc_done = bus_data_ok_i && bus_data_last_i &&
                    ((state_q == icache_pkg::UNC_DATA0 && !f2_valid_i[1]) ||
                     state_q == icache_pkg::UNC_DATA1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: begin
        if (need_line || need_unc) begin
          if (bus_busy_i) begin
            state_d = icache_pkg::WAIT_BUS;
          end else if (need_line) begin
            state_d = icache_pkg::LINE_ADDR;
          end else if (f2_valid_i[0]) begin
            state_d = icache_pkg::UNC_ADDR0;
          end else begin
            state_d = icache_pkg::UNC_ADDR1;
          end
        end
      end
      icache_pkg::WAIT_BUS: begin
        if (!bus_busy_i) state_d = icache_pkg::IDLE; // re-evaluate the group
      end
      icache_pkg::LINE_ADDR: begin
        if (bus_ready_i) state_d = icache_pkg::LINE_DATA;
      end
      icache_pkg::LINE_DATA: begin
        if (bus_data_ok_i && bus_data_last_i) state_d = icache_pkg::REREAD;
      end
      icache_pkg::UNC_ADDR0: begin
        if (bus_ready_i) state_d = icache_pkg::UNC_DATA0;
      end
      icache_pkg::UNC_DATA0: begin
        if (bus_data_ok_i && bus_data_last_i) begin
          state_d = f2_valid_i[1] ? icache_pkg::UNC_ADDR1 : icache_pkg::IDLE;
        end
      end
      icache_pkg::UNC_ADDR1: begin
        if (bus_ready_i) state_d = icache_pkg::UNC_DATA1;
      end
      icache_pkg::UNC_DATA1: begin
        if (bus_data_ok_i && bus_data_last_i) state_d = icache_pkg::IDLE;
      end
      default: state_d = icache_pkg::IDLE; // also leaves REREAD
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= icache_pkg::IDLE;
      beat_q   <= '0;
      served_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == icache_pkg::LINE_ADDR) begin
        beat_q <= '0;
      end else if (state_q == icache_pkg::LINE_DATA && bus_data_ok_i) begin
        beat_q <= beat_q + 1'b1;
      end
      if (unc_done) begin
        served_q <= 1'b1;
      end else if (!f2_stall_i) begin
        served_q <= 1'b0; // F2 moves on
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::IDLE) way_q <= victim_i;
    if (bus_data_ok_i && state_q == icache_pkg::UNC_DATA0) unc_q[0] <= bus_rdata_i;
    if (bus_data_ok_i && state_q == icache_pkg::UNC_DATA1) unc_q[1] <= bus_rdata_i;
  end

  always_comb begin
    bus_req_valid_o = state_q inside {icache_pkg::LINE_ADDR, icache_pkg::UNC_ADDR0,
                                      icache_pkg::UNC_ADDR1};
    bus_req_burst_o = state_q == icache_pkg::LINE_ADDR;
    bus_req_addr_o  = icache_pkg::pair_base(f2_ppc_i);
    if (state_q == icache_pkg::LINE_ADDR) begin
      bus_req_addr_o = {f2_ppc_i[31:4], 4'b0000};
    end else if (state_q == icache_pkg::UNC_ADDR1) begin
      bus_req_addr_o = icache_pkg::pair_base(f2_ppc_i) + 32'd4;
    end
  end

  // tag goes valid when the burst is accepted
  assign tag_we_o  = (state_q == icache_pkg::LINE_ADDR && bus_ready_i) ? way_q : '0;
  assign tag_set_o = icache_pkg::set_of(f2_ppc_i);
  assign tag_o     = icache_pkg::tag_of(f2_ppc_i);

  assign data_we_o   = (state_q == icache_pkg::LINE_DATA && bus_data_ok_i) ? way_q : '0;
  assign data_row_o  = {icache_pkg::set_of(f2_ppc_i), beat_q[1]};
  assign data_lane_o = {beat_q[0], !beat_q[0]};
  assign data_word_o = bus_rdata_i;

  assign unc_words_o = unc_q;
  assign busy_o      = state_q != icache_pkg::IDLE || need_line || need_unc;
  assign reread_o    = state_q == icache_pkg::REREAD;

endmodule

/* src/icache_fetch.sv */
`timescale 1ns/1ps

module icache_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [1:0]              valid_i,
  input  logic                    excp_i,
  input  icache_pkg::addr_t       vpc_i,
  input  icache_pkg::addr_t       ppc_i,
  input  logic                    uncached_i,
  input  logic                    flush_i,
  input  logic                    f1_stall_i,
  input  logic                    f2_stall_i,
  output logic [1:0]              valid_o,
  output icache_pkg::word_t [1:0] inst_o,
  output icache_pkg::addr_t       pc_o,
  output logic                    f2_stall_req_o,
  output logic                    bus_req_valid_o,
  output icache_pkg::addr_t       bus_req_addr_o,
  output logic                    bus_req_burst_o,
  input  logic                    bus_busy_i,
  input  logic                    bus_ready_i,
  input  logic                    bus_data_ok_i,
  input  logic                    bus_data_last_i,
  input  icache_pkg::word_t       bus_rdata_i
);

  logic [1:0]                                  f2_valid_q;
  logic                                        f2_excp_q;
  logic                                        f2_uncached_q;
  icache_pkg::addr_t                           f2_ppc_q;
  icache_pkg::addr_t                           f2_vpc_q;
  logic                                        f2_stall_q;
  logic                                        reread_q;
  logic                                        hold_arrays;
  icache_pkg::way_vec_t                        victim_q;
  icache_pkg::addr_t                           rd_addr;
  icache_pkg::tag_t [icache_pkg::WAY_CNT-1:0]  tag_rd;
  icache_pkg::way_vec_t                        tag_vld;
  icache_pkg::word_t [icache_pkg::WAY_CNT-1:0][1:0] data_rd;
  icache_pkg::way_vec_t                        hit_live, hit, hit_q;
  icache_pkg::word_t [1:0]                     pair_live, pair, pair_skid_q;
  icache_pkg::way_vec_t                        tag_we;
  icache_pkg::set_idx_t                        tag_set;
  icache_pkg::tag_t                            tag_wr;
  icache_pkg::way_vec_t                        data_we;
  icache_pkg::pair_idx_t                       data_row;
  logic [1:0]                                  data_lane;
  icache_pkg::word_t                           data_word;
  icache_pkg::word_t [1:0]                     unc_words;
  logic                                        refill_busy;
  logic                                        reread;
  logic                                        clear_busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f2_valid_q <= '0;
      f2_excp_q  <= 1'b0;
    end else if (flush_i) begin
      f2_valid_q <= '0;
      f2_excp_q  <= 1'b0;
    end else if (!f2_stall_i) begin
      f2_valid_q <= f1_stall_i ? 2'b00 : valid_i; // empty group when F1 holds
      f2_excp_q  <= excp_i && !f1_stall_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!f2_stall_i && !f1_stall_i) begin
      f2_uncached_q <= uncached_i;
      f2_ppc_q      <= ppc_i;
      f2_vpc_q      <= vpc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f2_stall_q <= 1'b0;
      reread_q   <= 1'b0;
      victim_q   <= icache_pkg::way_vec_t'(1);
    end else begin
      f2_stall_q <= f2_stall_i;
      reread_q   <= reread;
      if (|tag_we) begin
        victim_q <= {victim_q[icache_pkg::WAY_CNT-2:0], victim_q[icache_pkg::WAY_CNT-1]};
      end
    end
  end

  // index bits are untranslated, F1 reads with vpc
  assign rd_addr = reread ? f2_ppc_q : vpc_i;

  // arrays follow F1 while stalled, so keep the last good result
  assign hold_arrays = f2_stall_q && !reread_q;

  always_comb begin
    pair_live = '0;
    for (int w = 0; w < icache_pkg::WAY_CNT; w++) begin
      hit_live[w] = tag_vld[w] && (tag_rd[w] == icache_pkg::tag_of(f2_ppc_q));
      if (hit_live[w]) pair_live |= data_rd[w];
    end
  end

  assign hit  = hold_arrays ? hit_q : hit_live;
  assign pair = hold_arrays ? pair_skid_q : pair_live;

  always_ff @(posedge clk) begin
    hit_q       <= hit;
    pair_skid_q <= pair;
  end

  assign inst_o         = f2_uncached_q ? unc_words : pair;
  assign valid_o        = f2_valid_q & {2{!f2_stall_i}};
  assign pc_o           = f2_vpc_q;
  assign f2_stall_req_o = refill_busy || clear_busy;

  icache_tag_ram tag_ram_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .raddr_i      (icache_pkg::set_of(rd_addr)),
    .rdata_tag_o  (tag_rd),
    .rdata_valid_o(tag_vld),
    .waddr_i      (tag_set),
    .we_i         (tag_we),
    .wtag_i       (tag_wr),
    .wvalid_i     (1'b1),
    .clear_busy_o (clear_busy)
  );

  icache_data_ram data_ram_i (
    .clk    (clk),
    .raddr_i(icache_pkg::pair_of(rd_addr)),
    .rdata_o(data_rd),
    .waddr_i(data_row),
    .wlane_i(data_lane),
    .we_i   (data_we),
    .wdata_i(data_word)
  );

  icache_refill refill_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .f2_valid_i     (f2_valid_q),
    .f2_excp_i      (f2_excp_q),
    .f2_uncached_i  (f2_uncached_q),
    .f2_ppc_i       (f2_ppc_q),
    .f2_stall_i     (f2_stall_i),
    .miss_i         (~|hit),
    .victim_i       (victim_q),
    .bus_req_valid_o(bus_req_valid_o),
    .bus_req_addr_o (bus_req_addr_o),
    .bus_req_burst_o(bus_req_burst_o),
    .bus_busy_i     (bus_busy_i),
    .bus_ready_i    (bus_ready_i),
    .bus_data_ok_i  (bus_data_ok_i),
    .bus_data_last_i(bus_data_last_i),
    .bus_rdata_i    (bus_rdata_i),
    .tag_we_o       (tag_we),
    .tag_set_o      (tag_set),
    .tag_o          (tag_wr),
    .data_we_o      (data_we),
    .data_row_o     (data_row),
    .data_lane_o    (data_lane),
    .data_word_o    (data_word),
    .unc_words_o    (unc_words),
    .busy_o         (refill_busy),
    .reread_o       (reread)
  );

endmodule

/* verification/icache_fetch_props.sv */
`timescale 1ns/1ps

module icache_fetch_props (
  input logic             clk,
  input logic             rst_n,
  input logic             stall_i,
  input logic             stall_req_i,
  input logic [1:0]       out_valid_i,
  input logic [1:0][31:0] inst_i,
  input logic             req_valid_i,
  input logic [31:0]      req_addr_i,
  input logic             ready_i
);

  int unsigned fail_cnt = 0;

  req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_i && !ready_i |=> req_valid_i && $stable(req_addr_i))
    else begin
      fail_cnt++;
      $error("bus request dropped or its address moved before acceptance");
    end

  // an outside stall keeps the F2 pair in place
  inst_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i && !stall_req_i ##1 stall_i |-> $stable(inst_i))
    else begin
      fail_cnt++;
      $error("inst_o changed while F2 was held by an outside stall");
    end

  reset_quiet_a: assert property (@(posedge clk)
    !rst_n |=> out_valid_i == 2'b00 && !req_valid_i)
    else begin
      fail_cnt++;
      $error("valid_o or bus_req_valid_o high right after reset");
    end

endmodule

bind icache_fetch icache_fetch_props props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .stall_i    (f2_stall_i),
  .stall_req_i(f2_stall_req_o),
  .out_valid_i(valid_o),
  .inst_i     (inst_o),
  .req_valid_i(bus_req_valid_o),
  .req_addr_i (bus_req_addr_o),
  .ready_i    (bus_ready_i)
);

/* verification/icache_fetch_tb.sv */
`timescale 1ns/1ps

module icache_fetch_tb;

  logic             clk;
  logic             rst_n;
  logic [1:0]       valid_i;
  logic             excp_i;
  logic [31:0]      vpc_i;
  logic [31:0]      ppc_i;
  logic             uncached_i;
  logic             flush_i;
  logic             f1_stall_i;
  logic             f2_stall_i;
  logic [1:0]       valid_o;
  logic [1:0][31:0] inst_o;
  logic [31:0]      pc_o;
  logic             f2_stall_req_o;
  logic             bus_req_valid_o;
  logic [31:0]      bus_req_addr_o;
  logic             bus_req_burst_o;
  logic             bus_busy_i;
  logic             bus_ready_i;
  logic             bus_data_ok_i;
  logic             bus_data_last_i;
  logic [31:0]      bus_rdata_i;
  logic             extra_stall;
  logic [31:0]      rand_state;
  int               req_cnt;
  logic [31:0]      req_addr_q[$];
  logic             req_burst_q[$];

  icache_fetch icache_fetch_i (.*);

  always #50 clk = ~clk;

  assign f2_stall_i = f2_stall_req_o | extra_stall; // env must honour the stall request

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'h5a5a0000;
  endfunction

  // virtual alias keeps the page offset
  function automatic logic [31:0] vpc_of(input logic [31:0] ppc);
    return ppc ^ 32'hc0000000;
  endfunction

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  always @(negedge clk) begin
    if (icache_fetch_i.props_i.fail_cnt != 0) begin
      $display("a bound protocol assertion failed");
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  // memory model with random accept delay and random gaps between beats
  always begin : mem_model
    int          gap;
    int          beats;
    logic [31:0] addr;
    @(negedge clk);
    if (rst_n && bus_req_valid_o) begin
      addr = bus_req_addr_o;
      beats = bus_req_burst_o ? 4 : 1;
      req_cnt++;
      req_addr_q.push_back(addr);
      req_burst_q.push_back(bus_req_burst_o);
      gap = (next_rand() >> 16) % 4;
      tick();
      repeat (gap) tick();
      bus_ready_i = 1'b1;
      tick();
      bus_ready_i = 1'b0;
      for (int b = 0; b < beats; b++) begin
        gap = (next_rand() >> 16) % 3;
        repeat (gap) tick();
        bus_data_ok_i   = 1'b1;
        bus_data_last_i = (b == beats - 1);
        bus_rdata_i     = mem_word(addr + 32'(4 * b));
        tick();
        bus_data_ok_i   = 1'b0;
        bus_data_last_i = 1'b0;
      end
    end
  end

  task automatic wait_delivery(output int cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (f2_stall_i) begin
      n++;
      if (n > 400) report_timeout("F2 to deliver the group");
      @(negedge clk);
    end
    cycles = n;
  endtask

  // one group in F1 for a single cycle, then F1 runs dry
  task automatic fetch_pair(input logic [31:0] ppc, input logic [1:0] vld, input logic unc,
                            output int lat);
    logic [31:0] base;
    base       = ppc & ~32'h7;
    valid_i    = vld;
    ppc_i      = ppc;
    vpc_i      = vpc_of(ppc);
    uncached_i = unc;
    f1_stall_i = 1'b0;
    @(negedge clk);
    check_val("f2_stall_i", f2_stall_i, 0);
    tick();
    valid_i    = 2'b00;
    f1_stall_i = 1'b1;
    wait_delivery(lat);
    check_val("valid_o", valid_o, vld);
    if (vld[0]) check_val("inst_o[0]", inst_o[0], mem_word(base));
    if (vld[1]) check_val("inst_o[1]", inst_o[1], mem_word(base + 32'd4));
    check_val("pc_o", pc_o, vpc_of(ppc));
    tick();
  endtask

  task automatic fetch_miss(input logic [31:0] ppc);
    int n0;
    int lat;
    n0 = req_cnt;
    fetch_pair(ppc, 2'b11, 1'b0, lat);
    check_val("request count", req_cnt - n0, 1);
    check_val("bus_req_addr_o", req_addr_q[$], ppc & ~32'hf);
    check_val("bus_req_burst_o", req_burst_q[$], 1);
  endtask

  task automatic fetch_hit(input logic [31:0] ppc);
    int n0;
    int lat;
    n0 = req_cnt;
    fetch_pair(ppc, 2'b11, 1'b0, lat);
    check_val("hit latency", lat, 0);
    check_val("request count", req_cnt - n0, 0);
  endtask

  task automatic clear_after_reset();
    int n;
    n = 0;
    @(negedge clk);
    check_val("f2_stall_req_o", f2_stall_req_o, 1);
    while (f2_stall_req_o) begin
      n++;
      if (n > 300) report_timeout("the tag clear after reset");
      @(negedge clk);
    end
    check_val("valid_o", valid_o, 0);
    check_val("request count", req_cnt, 0);
    tick();
  endtask

  task automatic uncached_reads();
    int n0;
    int lat;
    n0 = req_cnt;
    fetch_pair(32'h2000_0108, 2'b11, 1'b1, lat);
    check_val("request count", req_cnt - n0, 2);
    check_val("bus_req_addr_o", req_addr_q[$-1], 32'h2000_0108);
    check_val("bus_req_burst_o", req_burst_q[$-1], 0);
    check_val("bus_req_addr_o", req_addr_q[$], 32'h2000_010c);
    check_val("bus_req_burst_o", req_burst_q[$], 0);
    n0 = req_cnt;
    fetch_pair(32'h2000_0200, 2'b10, 1'b1, lat); // slot 1 only
    check_val("request count", req_cnt - n0, 1);
    check_val("bus_req_addr_o", req_addr_q[$], 32'h2000_0204);
    check_val("bus_req_burst_o", req_burst_q[$], 0);
  endtask

  task automatic way_replacement();
    // three different tags in set 0x40
    fetch_miss(32'h0000_0400);
    fetch_miss(32'h0000_1408);
    fetch_miss(32'h0000_2400);
    fetch_hit(32'h0000_1400);
    fetch_miss(32'h0000_0408);
  endtask

  task automatic flush_and_stall();
    valid_i    = 2'b11;
    ppc_i      = 32'h0000_1230;
    vpc_i      = vpc_of(32'h0000_1230);
    uncached_i = 1'b0;
    f1_stall_i = 1'b0;
    @(negedge clk);
    check_val("f2_stall_i", f2_stall_i, 0);
    tick();
    flush_i = 1'b1; // F1 keeps presenting so flush must win
    @(negedge clk);
    check_val("valid_o", valid_o, 2'b11);
    tick();
    flush_i    = 1'b0;
    valid_i    = 2'b00;
    f1_stall_i = 1'b1;
    @(negedge clk);
    check_val("valid_o", valid_o, 0);
    tick();
    valid_i    = 2'b11;
    ppc_i      = 32'h0000_1238;
    vpc_i      = vpc_of(32'h0000_1238);
    f1_stall_i = 1'b0;
    @(negedge clk);
    check_val("f2_stall_i", f2_stall_i, 0);
    tick();
    extra_stall = 1'b1;
    valid_i     = 2'b00;
    f1_stall_i  = 1'b1;
    vpc_i       = 32'h0000_2400; // arrays now read another line
    repeat (4) begin
      @(negedge clk);
      check_val("valid_o", valid_o, 0);
      check_val("inst_o[0]", inst_o[0], mem_word(32'h0000_1238));
      check_val("inst_o[1]", inst_o[1], mem_word(32'h0000_123c));
    end
    tick();
    extra_stall = 1'b0;
    @(negedge clk);
    check_val("valid_o", valid_o, 2'b11);
    check_val("inst_o[0]", inst_o[0], mem_word(32'h0000_1238));
    check_val("inst_o[1]", inst_o[1], mem_word(32'h0000_123c));
    tick();
  endtask

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    valid_i         = 2'b00;
    excp_i          = 1'b0;
    vpc_i           = '0;
    ppc_i           = '0;
    uncached_i      = 1'b0;
    flush_i         = 1'b0;
    f1_stall_i      = 1'b1;
    extra_stall     = 1'b0;
    bus_busy_i      = 1'b0;
    bus_ready_i     = 1'b0;
    bus_data_ok_i   = 1'b0;
    bus_data_last_i = 1'b0;
    bus_rdata_i     = '0;
    rand_state      = 32'hb4e9;
    req_cnt         = 0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;
    clear_after_reset();
    fetch_miss(32'h0000_1230); // cold line in set 0x23
    fetch_hit(32'h0000_1238);
    uncached_reads();
    way_replacement();
    flush_and_stall();
    if (icache_fetch_i.props_i.fail_cnt != 0) begin
      $display("%0d protocol assertion failures", icache_fetch_i.props_i.fail_cnt);
      $display(">>> FAIL");
      $fatal(1);
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* compile.f */
src/icache_pkg.sv
src/icache_tag_ram.sv
src/icache_data_ram.sv
src/icache_refill.sv
src/icache_fetch.sv
verification/icache_fetch_props.sv
verification/icache_fetch_tb.sv

/* Bender.yml */
package:
  name: icache_fetch

sources:
  - files:
      - src/icache_pkg.sv
      - src/icache_tag_ram.sv
      - src/icache_data_ram.sv
      - src/icache_refill.sv
      - src/icache_fetch.sv
  - target: test
    files:
      - verification/icache_fetch_props.sv
      - verification/icache_fetch_tb.sv
